// ==== design/axi_lite_pkg.sv ====
`default_nettype none

package axi_lite_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int unsigned AXI_ADDR_W = 4;
    localparam int unsigned AXI_DATA_W = 32;
    localparam int unsigned AXI_STRB_W = AXI_DATA_W / 8;

    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [AXI_STRB_W-1:0] axi_strb_t;
    typedef logic [1:0]            axi_resp_t;

    // Only OKAY and SLVERR are ever returned
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Word index sits above the byte offset
    localparam int unsigned ADDR_LSB  = 2;
    localparam int unsigned REG_IDX_W = AXI_ADDR_W - ADDR_LSB;

    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    localparam reg_idx_t REG_ADDR   = 2'd0;
    localparam reg_idx_t REG_WDATA  = 2'd1;
    localparam reg_idx_t REG_CTRL   = 2'd2;
    localparam reg_idx_t REG_STATUS = 2'd3;

endpackage

`default_nettype wire

// ==== design/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // ------------------------------
    // External bus widths
    // ------------------------------
    localparam int unsigned WB_ADR_W = 7;
    localparam int unsigned WB_DAT_W = 8;

    typedef logic [WB_ADR_W-1:0] wb_adr_t;
    typedef logic [WB_DAT_W-1:0] wb_dat_t;

    // ------------------------------
    // Cycle limits
    // ------------------------------
    // Retries allowed before a further rty_i fails the cycle
    localparam int unsigned MAX_RETRY      = 3;
    // Strobed cycles without wait or response before giving up
    localparam int unsigned TIMEOUT_CYCLES = 32;

    typedef logic [$clog2(MAX_RETRY + 1)-1:0] retry_cnt_t;
    typedef logic [$clog2(TIMEOUT_CYCLES)-1:0] tmo_cnt_t;

    // Framer states
    typedef enum logic [1:0] {
        IDLE,
        STROBE,
        BACKOFF,
        FINISH
    } wb_state_t;

endpackage

`default_nettype wire

// ==== design/wb_cmd_if.sv ====
`default_nettype none

interface wb_cmd_if;
    import wb_pkg::*;

    // Command side, driven by the register block
    logic    start;
    logic    we;
    wb_adr_t adr;
    wb_dat_t wdat;

    // Result side, driven by the cycle framer
    logic    busy;
    logic    done;
    logic    fail;
    wb_dat_t rdat;

    // Register block issues one command at a time
    modport master (
        output start, we, adr, wdat,
        input  busy, done, fail, rdat
    );

    // Framer answers with done, fail and rdat in the same cycle
    modport slave (
        input  start, we, adr, wdat,
        output busy, done, fail, rdat
    );

endinterface

`default_nettype wire

// ==== design/axi_wb_regs.sv ====
`default_nettype none

module axi_wb_regs (
    input  wire                          S_AXI_ACLK,
    input  wire                          S_AXI_ARESETN,
    // Write address and data channels
    input  wire axi_lite_pkg::axi_addr_t S_AXI_AWADDR_i,
    input  wire [2:0]                    S_AXI_AWPROT_i,
    input  wire                          S_AXI_AWVALID_i,
    output logic                         S_AXI_AWREADY_o,
    input  wire axi_lite_pkg::axi_data_t S_AXI_WDATA_i,
    input  wire axi_lite_pkg::axi_strb_t S_AXI_WSTRB_i,
    input  wire                          S_AXI_WVALID_i,
    output logic                         S_AXI_WREADY_o,
    // Write response channel
    output axi_lite_pkg::axi_resp_t      S_AXI_BRESP_o,
    output logic                         S_AXI_BVALID_o,
    input  wire                          S_AXI_BREADY_i,
    // Read channels
    input  wire axi_lite_pkg::axi_addr_t S_AXI_ARADDR_i,
    input  wire [2:0]                    S_AXI_ARPROT_i,
    input  wire                          S_AXI_ARVALID_i,
    output logic                         S_AXI_ARREADY_o,
    output axi_lite_pkg::axi_data_t      S_AXI_RDATA_o,
    output axi_lite_pkg::axi_resp_t      S_AXI_RRESP_o,
    output logic                         S_AXI_RVALID_o,
    input  wire                          S_AXI_RREADY_i,
    // Command path to the framer
    wb_cmd_if.master                     cmd
);
    import axi_lite_pkg::*;
    import wb_pkg::*;

    // Protection attributes on AWPROT and ARPROT have no effect here

    logic      wr_pend;
    logic      wr_en;
    logic      rd_en;
    reg_idx_t  wr_word;
    reg_idx_t  rd_word;
    logic      is_cmd;
    logic      launch;
    logic      reject;
    logic      cmd_pend;
    logic      cmd_rd;
    wb_adr_t   addr_q;
    wb_dat_t   rbyte_q;
    logic      fail_q;
    axi_data_t status_word;
    axi_data_t rd_mux;

    // ------------------------------
    // Write address and data
    // ------------------------------
    // Both ready flags pulse together, no new write until B completes
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            S_AXI_AWREADY_o <= 1'b0;
            S_AXI_WREADY_o  <= 1'b0;
            wr_pend         <= 1'b0;
        end
        else if (S_AXI_AWVALID_i && S_AXI_WVALID_i && !wr_pend)
        begin
            S_AXI_AWREADY_o <= 1'b1;
            S_AXI_WREADY_o  <= 1'b1;
            wr_pend         <= 1'b1;
        end
        else
        begin
            S_AXI_AWREADY_o <= 1'b0;
            S_AXI_WREADY_o  <= 1'b0;
            if (S_AXI_BVALID_o && S_AXI_BREADY_i)
            begin
                wr_pend <= 1'b0;
            end
        end
    end

    assign wr_en   = S_AXI_AWREADY_o && S_AXI_AWVALID_i && S_AXI_WREADY_o && S_AXI_WVALID_i;
    assign wr_word = S_AXI_AWADDR_i[ADDR_LSB +: REG_IDX_W];

    // Which writes are bus commands
    always_comb
    begin
        case (wr_word)
            REG_WDATA: is_cmd = S_AXI_WSTRB_i[0];
            REG_CTRL:  is_cmd = S_AXI_WSTRB_i[0] && S_AXI_WDATA_i[0];
            default:   is_cmd = 1'b0;
        endcase
    end

    // Framer still working, so the command bounces with SLVERR
    assign launch = wr_en && is_cmd && !cmd.busy;
    assign reject = wr_en && is_cmd && cmd.busy;

    assign cmd.start = launch;
    assign cmd.we    = (wr_word == REG_WDATA);
    assign cmd.adr   = addr_q;
    assign cmd.wdat  = S_AXI_WDATA_i[WB_DAT_W-1:0];

    // Wishbone address lives in byte 0 of word 0
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            addr_q <= '0;
        end
        else if (wr_en && (wr_word == REG_ADDR) && S_AXI_WSTRB_i[0])
        begin
            addr_q <= S_AXI_WDATA_i[WB_ADR_W-1:0];
        end
    end

    // ------------------------------
    // Write response and results
    // ------------------------------
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            S_AXI_BVALID_o <= 1'b0;
            S_AXI_BRESP_o  <= RESP_OKAY;
            cmd_pend       <= 1'b0;
            cmd_rd         <= 1'b0;
            rbyte_q        <= '0;
            fail_q         <= 1'b0;
        end
        else if (launch)
        begin
            // Hold B back until the bus cycle ends
            cmd_pend <= 1'b1;
            cmd_rd   <= (wr_word == REG_CTRL);
        end
        else if (wr_en)
        begin
            S_AXI_BVALID_o <= 1'b1;
            S_AXI_BRESP_o  <= reject ? RESP_SLVERR : RESP_OKAY;
        end
        else if (cmd_pend && cmd.done)
        begin
            cmd_pend       <= 1'b0;
            fail_q         <= cmd.fail;
            S_AXI_BVALID_o <= 1'b1;
            S_AXI_BRESP_o  <= cmd.fail ? RESP_SLVERR : RESP_OKAY;
            if (cmd_rd && !cmd.fail)
            begin
                rbyte_q <= cmd.rdat;
            end
        end
        else if (S_AXI_BVALID_o && S_AXI_BREADY_i)
        begin
            S_AXI_BVALID_o <= 1'b0;
        end
    end

    // ------------------------------
    // Read channel
    // ------------------------------
    assign rd_en       = S_AXI_ARREADY_o && S_AXI_ARVALID_i;
    assign rd_word     = S_AXI_ARADDR_i[ADDR_LSB +: REG_IDX_W];
    assign status_word = axi_data_t'({fail_q, cmd.busy, rbyte_q});

    // WDATA and CTRL read back as zero
    always_comb
    begin
        case (rd_word)
            REG_ADDR:   rd_mux = axi_data_t'(addr_q);
            REG_STATUS: rd_mux = status_word;
            default:    rd_mux = '0;
        endcase
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            S_AXI_ARREADY_o <= 1'b0;
            S_AXI_RVALID_o  <= 1'b0;
            S_AXI_RDATA_o   <= '0;
        end
        else
        begin
            // No new address while a read is in flight
            S_AXI_ARREADY_o <= !S_AXI_ARREADY_o && S_AXI_ARVALID_i && !S_AXI_RVALID_o;
            if (rd_en)
            begin
                S_AXI_RVALID_o <= 1'b1;
                S_AXI_RDATA_o  <= rd_mux;
            end
            else if (S_AXI_RVALID_o && S_AXI_RREADY_i)
            begin
                S_AXI_RVALID_o <= 1'b0;
            end
        end
    end

    assign S_AXI_RRESP_o = RESP_OKAY;

endmodule

`default_nettype wire

// ==== design/wb_cycle.sv ====
`default_nettype none

module wb_cycle (
    input  wire                   S_AXI_ACLK,
    input  wire                   S_AXI_ARESETN,
    wb_cmd_if.slave               cmd,
    // Wishbone B4 master side
    output logic                  cyc_o,
    output logic                  stb_o,
    output logic                  we_o,
    output wb_pkg::wb_adr_t       adr_o,
    output wb_pkg::wb_dat_t       dat_o,
    input  wire                   ack_i,
    input  wire                   wat_i,
    input  wire                   rty_i,
    input  wire                   err_i,
    input  wire wb_pkg::wb_dat_t  dat_i
);
    import wb_pkg::*;

    wb_state_t  state;
    retry_cnt_t retries;
    tmo_cnt_t   idle_cnt;
    logic       fail_q;
    logic       we_q;
    wb_adr_t    adr_q;
    wb_dat_t    dat_q;
    wb_dat_t    rdat_q;

    // ------------------------------
    // Cycle FSM
    // ------------------------------
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            state    <= IDLE;
            retries  <= '0;
            idle_cnt <= '0;
            fail_q   <= 1'b0;
            we_q     <= 1'b0;
            adr_q    <= '0;
            dat_q    <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (cmd.start)
                    begin
                        // Latch the command for the bus outputs
                        we_q     <= cmd.we;
                        adr_q    <= cmd.adr;
                        dat_q    <= cmd.wdat;
                        retries  <= '0;
                        idle_cnt <= '0;
                        fail_q   <= 1'b0;
                        state    <= STROBE;
                    end
                STROBE:
                    if (ack_i)
                    begin
                        state <= FINISH;
                    end
                    else if (err_i)
                    begin
                        fail_q <= 1'b1;
                        state  <= FINISH;
                    end
                    else if (rty_i)
                    begin
                        // Retry budget spent
                        if (retries == retry_cnt_t'(MAX_RETRY))
                        begin
                            fail_q <= 1'b1;
                            state  <= FINISH;
                        end
                        else
                        begin
                            retries  <= retries + 1'b1;
                            idle_cnt <= '0;
                            state    <= BACKOFF;
                        end
                    end
                    else if (!wat_i)
                    begin
                        // Target is not stalling yet says nothing
                        if (idle_cnt == tmo_cnt_t'(TIMEOUT_CYCLES - 1))
                        begin
                            fail_q <= 1'b1;
                            state  <= FINISH;
                        end
                        else
                        begin
                            idle_cnt <= idle_cnt + 1'b1;
                        end
                    end
                // One idle cycle before the strobe goes out again
                BACKOFF: state <= STROBE;
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Read byte is only meaningful after an ack
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            rdat_q <= '0;
        end
        else if ((state == STROBE) && ack_i)
        begin
            rdat_q <= dat_i;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------
    assign cyc_o = (state == STROBE);
    assign stb_o = (state == STROBE);
    assign we_o  = we_q;
    assign adr_o = adr_q;
    assign dat_o = dat_q;

    // Busy stays high through FINISH and overlaps done by one cycle
    assign cmd.busy = (state != IDLE);
    assign cmd.done = (state == FINISH);
    assign cmd.fail = fail_q;
    assign cmd.rdat = rdat_q;

endmodule

`default_nettype wire

// ==== design/axi_wb_bridge_top.sv ====
`default_nettype none

module axi_wb_bridge_top (
    input  wire                          S_AXI_ACLK,
    input  wire                          S_AXI_ARESETN,
    // AXI4-Lite slave
    input  wire axi_lite_pkg::axi_addr_t S_AXI_AWADDR_i,
    input  wire [2:0]                    S_AXI_AWPROT_i,
    input  wire                          S_AXI_AWVALID_i,
    output wire                          S_AXI_AWREADY_o,
    input  wire axi_lite_pkg::axi_data_t S_AXI_WDATA_i,
    input  wire axi_lite_pkg::axi_strb_t S_AXI_WSTRB_i,
    input  wire                          S_AXI_WVALID_i,
    output wire                          S_AXI_WREADY_o,
    output wire axi_lite_pkg::axi_resp_t S_AXI_BRESP_o,
    output wire                          S_AXI_BVALID_o,
    input  wire                          S_AXI_BREADY_i,
    input  wire axi_lite_pkg::axi_addr_t S_AXI_ARADDR_i,
    input  wire [2:0]                    S_AXI_ARPROT_i,
    input  wire                          S_AXI_ARVALID_i,
    output wire                          S_AXI_ARREADY_o,
    output wire axi_lite_pkg::axi_data_t S_AXI_RDATA_o,
    output wire axi_lite_pkg::axi_resp_t S_AXI_RRESP_o,
    output wire                          S_AXI_RVALID_o,
    input  wire                          S_AXI_RREADY_i,
    // Wishbone B4 master, 8-bit data
    output wire                          cyc_o,
    output wire                          stb_o,
    output wire                          we_o,
    output wire wb_pkg::wb_adr_t         adr_o,
    output wire wb_pkg::wb_dat_t         dat_o,
    input  wire                          ack_i,
    input  wire                          wat_i,
    input  wire                          rty_i,
    input  wire                          err_i,
    input  wire wb_pkg::wb_dat_t         dat_i
);

    // Command and result link between the two blocks
    wb_cmd_if cmd_bus ();

    // ------------------------------
    // Register block
    // ------------------------------
    axi_wb_regs u_regs (
        .S_AXI_ACLK      (S_AXI_ACLK),
        .S_AXI_ARESETN   (S_AXI_ARESETN),
        .S_AXI_AWADDR_i  (S_AXI_AWADDR_i),
        .S_AXI_AWPROT_i  (S_AXI_AWPROT_i),
        .S_AXI_AWVALID_i (S_AXI_AWVALID_i),
        .S_AXI_AWREADY_o (S_AXI_AWREADY_o),
        .S_AXI_WDATA_i   (S_AXI_WDATA_i),
        .S_AXI_WSTRB_i   (S_AXI_WSTRB_i),
        .S_AXI_WVALID_i  (S_AXI_WVALID_i),
        .S_AXI_WREADY_o  (S_AXI_WREADY_o),
        .S_AXI_BRESP_o   (S_AXI_BRESP_o),
        .S_AXI_BVALID_o  (S_AXI_BVALID_o),
        .S_AXI_BREADY_i  (S_AXI_BREADY_i),
        .S_AXI_ARADDR_i  (S_AXI_ARADDR_i),
        .S_AXI_ARPROT_i  (S_AXI_ARPROT_i),
        .S_AXI_ARVALID_i (S_AXI_ARVALID_i),
        .S_AXI_ARREADY_o (S_AXI_ARREADY_o),
        .S_AXI_RDATA_o   (S_AXI_RDATA_o),
        .S_AXI_RRESP_o   (S_AXI_RRESP_o),
        .S_AXI_RVALID_o  (S_AXI_RVALID_o),
        .S_AXI_RREADY_i  (S_AXI_RREADY_i),
        .cmd             (cmd_bus)
    );

    // ------------------------------
    // Cycle framer
    // ------------------------------
    wb_cycle u_cycle (
        .S_AXI_ACLK    (S_AXI_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .cmd           (cmd_bus),
        .cyc_o         (cyc_o),
        .stb_o         (stb_o),
        .we_o          (we_o),
        .adr_o         (adr_o),
        .dat_o         (dat_o),
        .ack_i         (ack_i),
        .wat_i         (wat_i),
        .rty_i         (rty_i),
        .err_i         (err_i),
        .dat_i         (dat_i)
    );

endmodule

`default_nettype wire

// ==== sim/wb_target_model.sv ====
`default_nettype none

module wb_target_model (
    input  wire                  clk_i,
    input  wire                  rst_n_i,
    input  wire                  cyc_i,
    input  wire                  stb_i,
    input  wire                  we_i,
    input  wire wb_pkg::wb_adr_t adr_i,
    input  wire wb_pkg::wb_dat_t dat_i,
    output logic                 ack_o,
    output logic                 wat_o,
    output logic                 rty_o,
    output logic                 err_o,
    output wb_pkg::wb_dat_t      dat_o
);
    import wb_pkg::*;

    // Reply kinds, same codes as in the testbench
    localparam logic [1:0] KIND_ACK    = 2'd0;
    localparam logic [1:0] KIND_ERR    = 2'd1;
    localparam logic [1:0] KIND_SILENT = 2'd2;

    // Retries come first, then wait cycles, then the final reply
    typedef struct packed {
        logic [1:0] kind;
        logic [7:0] waits;
        logic [3:0] rtys;
    } reply_t;

    wb_dat_t mem [0:127];
    reply_t  script [$];
    reply_t  cur;
    logic    active;
    logic    cyc_q;

    // Queue one reply for a later transfer
    task automatic add_reply(input logic [1:0] kind, input int waits, input int rtys);
        reply_t r;
        r.kind  = kind;
        r.waits = 8'(waits);
        r.rtys  = 4'(rtys);
        script.push_back(r);
    endtask

    initial
    begin
        int i;
        // Odd multiplier, every address gets its own byte
        for (i = 0; i < 128; i++)
        begin
            mem[i] = wb_dat_t'(i * 37 + 11);
        end
        ack_o  = 1'b0;
        wat_o  = 1'b0;
        rty_o  = 1'b0;
        err_o  = 1'b0;
        dat_o  = '0;
        active = 1'b0;
        cyc_q  = 1'b0;
    end

    always @(posedge clk_i)
    begin
        ack_o <= 1'b0;
        rty_o <= 1'b0;
        err_o <= 1'b0;
        wat_o <= 1'b0;
        cyc_q <= cyc_i;
        if (!rst_n_i)
        begin
            active = 1'b0;
        end
        // Two idle cycles end a transfer
        // A single idle cycle is only the retry backoff
        else if (!cyc_i && !cyc_q)
        begin
            active = 1'b0;
        end
        else if (cyc_i && stb_i && !ack_o && !rty_o && !err_o)
        begin
            if (!active)
            begin
                active = 1'b1;
                if (script.size() != 0)
                begin
                    cur = script.pop_front();
                end
                else
                begin
                    cur = '{KIND_SILENT, 8'd0, 4'd0};
                end
            end
            if (cur.rtys != 4'd0)
            begin
                rty_o    <= 1'b1;
                cur.rtys = cur.rtys - 4'd1;
            end
            else if (cur.waits != 8'd0)
            begin
                wat_o     <= 1'b1;
                cur.waits = cur.waits - 8'd1;
            end
            else if (cur.kind == KIND_ACK)
            begin
                ack_o <= 1'b1;
                dat_o <= mem[adr_i];
                if (we_i)
                begin
                    mem[adr_i] <= dat_i;
                end
            end
            else if (cur.kind == KIND_ERR)
            begin
                err_o <= 1'b1;
            end
            // Silent target just lets the strobe hang
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_axi_wb_bridge.sv ====
`default_nettype none

module tb_axi_wb_bridge;
    import axi_lite_pkg::*;
    import wb_pkg::*;

    localparam int         WAIT_LIMIT  = 200;
    localparam logic [1:0] KIND_ACK    = 2'd0;
    localparam logic [1:0] KIND_ERR    = 2'd1;
    localparam logic [1:0] KIND_SILENT = 2'd2;

    logic      clk = 1'b0;
    logic      rst_n;
    // AXI4-Lite master side
    axi_addr_t awaddr;
    logic [2:0] awprot;
    logic      awvalid;
    logic      awready;
    axi_data_t wdata;
    axi_strb_t wstrb;
    logic      wvalid;
    logic      wready;
    axi_resp_t bresp;
    logic      bvalid;
    logic      bready;
    axi_addr_t araddr;
    logic [2:0] arprot;
    logic      arvalid;
    logic      arready;
    axi_data_t rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;
    // Wishbone between bridge and target
    logic      wb_cyc;
    logic      wb_stb;
    logic      wb_we;
    wb_adr_t   wb_adr;
    wb_dat_t   wb_wdat;
    logic      wb_ack;
    logic      wb_wat;
    logic      wb_rty;
    logic      wb_err;
    wb_dat_t   wb_rdat;

    // Reference state
    wb_dat_t   ref_mem [0:127];
    wb_dat_t   exp_rbyte;
    wb_adr_t   exp_addr;
    logic      exp_we;
    wb_adr_t   exp_adr;
    wb_dat_t   exp_dat;
    int        ack_count = 0;

    always #4 clk = ~clk;

    axi_wb_bridge_top u_dut (
        .S_AXI_ACLK      (clk),
        .S_AXI_ARESETN   (rst_n),
        .S_AXI_AWADDR_i  (awaddr),
        .S_AXI_AWPROT_i  (awprot),
        .S_AXI_AWVALID_i (awvalid),
        .S_AXI_AWREADY_o (awready),
        .S_AXI_WDATA_i   (wdata),
        .S_AXI_WSTRB_i   (wstrb),
        .S_AXI_WVALID_i  (wvalid),
        .S_AXI_WREADY_o  (wready),
        .S_AXI_BRESP_o   (bresp),
        .S_AXI_BVALID_o  (bvalid),
        .S_AXI_BREADY_i  (bready),
        .S_AXI_ARADDR_i  (araddr),
        .S_AXI_ARPROT_i  (arprot),
        .S_AXI_ARVALID_i (arvalid),
        .S_AXI_ARREADY_o (arready),
        .S_AXI_RDATA_o   (rdata),
        .S_AXI_RRESP_o   (rresp),
        .S_AXI_RVALID_o  (rvalid),
        .S_AXI_RREADY_i  (rready),
        .cyc_o           (wb_cyc),
        .stb_o           (wb_stb),
        .we_o            (wb_we),
        .adr_o           (wb_adr),
        .dat_o           (wb_wdat),
        .ack_i           (wb_ack),
        .wat_i           (wb_wat),
        .rty_i           (wb_rty),
        .err_i           (wb_err),
        .dat_i           (wb_rdat)
    );

    wb_target_model u_target (
        .clk_i   (clk),
        .rst_n_i (rst_n),
        .cyc_i   (wb_cyc),
        .stb_i   (wb_stb),
        .we_i    (wb_we),
        .adr_i   (wb_adr),
        .dat_i   (wb_wdat),
        .ack_o   (wb_ack),
        .wat_o   (wb_wat),
        .rty_o   (wb_rty),
        .err_o   (wb_err),
        .dat_o   (wb_rdat)
    );

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            stop_with_fail($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    function automatic axi_addr_t reg_addr(input reg_idx_t idx);
        return {idx, 2'b00};
    endfunction

    // Expected {BRESP, STATUS} once a command has finished
    function automatic logic [33:0] ref_result(input logic is_read, input wb_adr_t adr,
                                               input logic [1:0] kind, input int rtys);
        logic    fail;
        wb_dat_t rbyte;
        fail  = (kind != KIND_ACK) || (rtys > int'(MAX_RETRY));
        rbyte = (is_read && !fail) ? ref_mem[adr] : exp_rbyte;
        return {fail ? RESP_SLVERR : RESP_OKAY, 22'h0, fail, 1'b0, rbyte};
    endfunction

    // ------------------------------
    // Wishbone monitor
    // ------------------------------
    // Every acknowledged transfer must match the command in flight
    always @(posedge clk)
    begin
        if (wb_ack)
        begin
            ack_count <= ack_count + 1;
            check("cyc_o", 32'(wb_cyc), 32'd1);
            check("stb_o", 32'(wb_stb), 32'd1);
            check("we_o", 32'(wb_we), 32'(exp_we));
            check("adr_o", 32'(wb_adr), 32'(exp_adr));
            if (exp_we)
            begin
                check("dat_o", 32'(wb_wdat), 32'(exp_dat));
            end
        end
    end

    // ------------------------------
    // AXI4-Lite driver tasks
    // ------------------------------
    task automatic axi_write(input axi_addr_t addr, input axi_data_t data,
                             input axi_strb_t strb, output axi_resp_t resp);
        int cnt;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= 1'b1;
        cnt = 0;
        do
        begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT)
                stop_with_fail("timeout: write address and data were never accepted");
        end while (!awready);
        check("WREADY", 32'(wready), 32'd1);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        // Latency depends on the Wishbone cycle behind a command
        cnt = 0;
        do
        begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT)
                stop_with_fail("timeout: no write response from the bridge");
        end while (!bvalid);
        resp = bresp;
        @(posedge clk);
    endtask

    task automatic axi_read(input axi_addr_t addr, output axi_data_t data,
                            output axi_resp_t resp);
        int cnt;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        cnt = 0;
        do
        begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT)
                stop_with_fail("timeout: read address was never accepted");
        end while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        cnt = 0;
        do
        begin
            @(negedge clk);
            cnt++;
            if (cnt > WAIT_LIMIT)
                stop_with_fail("timeout: no read data from the bridge");
        end while (!rvalid);
        data = rdata;
        resp = rresp;
        @(posedge clk);
    endtask

    // Sets the address, launches one command and checks response, status and memory
    task automatic run_command(input logic is_read, input wb_adr_t adr, input wb_dat_t data,
                               input logic [1:0] kind, input int waits, input int rtys);
        axi_resp_t   resp;
        axi_data_t   status;
        logic [33:0] expect_v;
        int          acks_before;
        axi_write(reg_addr(REG_ADDR), axi_data_t'(adr), 4'hF, resp);
        check("BRESP addr", 32'(resp), 32'(RESP_OKAY));
        expect_v    = ref_result(is_read, adr, kind, rtys);
        exp_we      = !is_read;
        exp_adr     = adr;
        exp_dat     = data;
        acks_before = ack_count;
        u_target.add_reply(kind, waits, rtys);
        if (is_read)
            axi_write(reg_addr(REG_CTRL), 32'h1, 4'h1, resp);
        else
            axi_write(reg_addr(REG_WDATA), {24'($urandom()), data}, 4'h1, resp);
        check("BRESP", 32'(resp), 32'(expect_v[33:32]));
        check("ack count", 32'(ack_count), 32'(acks_before + (expect_v[9] ? 0 : 1)));
        axi_read(reg_addr(REG_STATUS), status, resp);
        check("STATUS", status, expect_v[31:0]);
        check("RRESP", 32'(resp), 32'(RESP_OKAY));
        if (!expect_v[9])
        begin
            if (is_read)
                exp_rbyte = ref_mem[adr];
            else
                ref_mem[adr] = data;
        end
        check("target memory", 32'(u_target.mem[adr]), 32'(ref_mem[adr]));
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial
    begin
        int          i;
        int          cnt;
        axi_data_t   data;
        axi_strb_t   strb;
        axi_resp_t   resp;
        axi_data_t   rd;
        axi_data_t   rd_busy;
        axi_resp_t   resp_busy;
        logic [33:0] expect_v;
        wb_adr_t     adr;
        wb_dat_t     wbyte;

        rst_n     = 1'b0;
        awaddr    = '0;
        awprot    = 3'b000;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b1;
        araddr    = '0;
        arprot    = 3'b000;
        arvalid   = 1'b0;
        rready    = 1'b1;
        exp_rbyte = '0;
        exp_addr  = '0;
        exp_we    = 1'b0;
        exp_adr   = '0;
        exp_dat   = '0;
        void'($urandom(58174));

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        // Reference copy starts from the target's fill pattern
        for (i = 0; i < 128; i++)
        begin
            ref_mem[i] = u_target.mem[i];
        end

        // ADDR register with random strobes where only byte 0 lands
        for (i = 0; i < 8; i++)
        begin
            data = $urandom();
            strb = axi_strb_t'($urandom_range(0, 15));
            axi_write(reg_addr(REG_ADDR), data, strb, resp);
            check("BRESP addr", 32'(resp), 32'(RESP_OKAY));
            if (strb[0])
                exp_addr = data[6:0];
            axi_read(reg_addr(REG_ADDR), rd, resp);
            check("ADDR readback", rd, 32'(exp_addr));
            check("RRESP", 32'(resp), 32'(RESP_OKAY));
        end

        // STATUS is read only and a write there is just acknowledged
        axi_write(reg_addr(REG_STATUS), 32'hFFFF_FFFF, 4'hF, resp);
        check("BRESP status write", 32'(resp), 32'(RESP_OKAY));

        // Wishbone writes with random wait counts
        for (i = 0; i < 6; i++)
        begin
            run_command(1'b0, wb_adr_t'($urandom_range(0, 127)), wb_dat_t'($urandom()),
                        KIND_ACK, int'($urandom_range(0, 5)), 0);
        end

        // Wishbone reads
        for (i = 0; i < 6; i++)
        begin
            run_command(1'b1, wb_adr_t'($urandom_range(0, 127)), 8'h00,
                        KIND_ACK, int'($urandom_range(0, 5)), 0);
        end

        // Error, retry and timeout replies
        run_command(1'b1, 7'h11, 8'h00, KIND_ERR, 0, 0);
        run_command(1'b1, 7'h22, 8'h00, KIND_ACK, 1, int'(MAX_RETRY));
        run_command(1'b0, 7'h33, 8'hA5, KIND_ACK, 0, int'(MAX_RETRY) + 1);
        run_command(1'b1, 7'h44, 8'h00, KIND_SILENT, 0, 0);
        run_command(1'b1, 7'h55, 8'h00, KIND_ACK, int'(TIMEOUT_CYCLES) + 8, 0);

        // Busy is set during a slow write and clear after its response
        adr   = wb_adr_t'($urandom_range(0, 127));
        wbyte = wb_dat_t'($urandom());
        axi_write(reg_addr(REG_ADDR), axi_data_t'(adr), 4'h1, resp);
        check("BRESP addr", 32'(resp), 32'(RESP_OKAY));
        expect_v = ref_result(1'b0, adr, KIND_ACK, 0);
        exp_we   = 1'b1;
        exp_adr  = adr;
        exp_dat  = wbyte;
        u_target.add_reply(KIND_ACK, 20, 0);
        fork
            begin
                axi_write(reg_addr(REG_WDATA), axi_data_t'(wbyte), 4'h1, resp);
            end
            begin
                cnt = 0;
                while (!wb_cyc)
                begin
                    @(negedge clk);
                    cnt++;
                    if (cnt > WAIT_LIMIT)
                        stop_with_fail("timeout: Wishbone cycle never started");
                end
                axi_read(reg_addr(REG_STATUS), rd_busy, resp_busy);
                check("STATUS busy", 32'(rd_busy[8]), 32'd1);
                check("RRESP busy", 32'(resp_busy), 32'(RESP_OKAY));
            end
        join
        check("BRESP", 32'(resp), 32'(expect_v[33:32]));
        ref_mem[adr] = wbyte;
        axi_read(reg_addr(REG_STATUS), rd, resp);
        check("STATUS", rd, expect_v[31:0]);
        check("target memory", 32'(u_target.mem[adr]), 32'(ref_mem[adr]));

        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
design/axi_lite_pkg.sv
design/wb_pkg.sv
design/wb_cmd_if.sv
design/axi_wb_regs.sv
design/wb_cycle.sv
design/axi_wb_bridge_top.sv
sim/wb_target_model.sv
sim/tb_axi_wb_bridge.sv

// ==== Makefile ====
# Verilator build and run of the AXI4-Lite to Wishbone bridge testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing -j 0 --top-module tb_axi_wb_bridge -f build.f -o tb_sim
	-./obj_dir/tb_sim > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG) || ! grep -q '>>> PASS' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)
